// File: rtl/gnss_macros.svh
`ifndef GNSS_MACROS_SVH
`define GNSS_MACROS_SVH

////////////////////
// Channel bank
////////////////////

// Correlator channels in the bank.
`define N_CHANNELS 4

// Samples per integration period.
`define DUMP_LEN 64

////////////////////
// Field widths
////////////////////

`define NCO_W 32
`define ACC_W 16
`define PWR_W 32

// Host bus.
`define APB_AW 8
`define APB_DW 32

`endif

// File: rtl/gnss_pkg.sv
`include "gnss_macros.svh"

package gnss_pkg;

   // Sign/magnitude sample, sign 1 is negative, mag 1 is a value of 3.
   typedef struct packed {
      logic sign;
      logic mag;
   } sample_t;

   // Carrier table entry, one of -1, 0, +1.
   typedef logic signed [1:0] carr_t;

   typedef logic [4:0] prn_t;

   // Two G2 stage numbers, 1 to 10.
   typedef logic [1:0][3:0] tap_pair_t;

   typedef struct packed {
      logic signed [`ACC_W-1:0] i_sum;
      logic signed [`ACC_W-1:0] q_sum;
      logic [`PWR_W-1:0]        power;
      logic                     ready;
      logic                     overrun;
   } chan_res_t;

   // G2 phase selector taps, PRN 1 to 10.
   function automatic tap_pair_t prn_taps(input prn_t prn);
      case (prn)
         5'd2:    prn_taps = {4'd3, 4'd7};
         5'd3:    prn_taps = {4'd4, 4'd8};
         5'd4:    prn_taps = {4'd5, 4'd9};
         5'd5:    prn_taps = {4'd1, 4'd9};
         5'd6:    prn_taps = {4'd2, 4'd10};
         5'd7:    prn_taps = {4'd1, 4'd8};
         5'd8:    prn_taps = {4'd2, 4'd9};
         5'd9:    prn_taps = {4'd3, 4'd10};
         5'd10:   prn_taps = {4'd2, 4'd3};
         // PRN 1 and anything unsupported.
         default: prn_taps = {4'd2, 4'd6};
      endcase
   endfunction

endpackage

// File: rtl/gnss_ifs.sv
`timescale 1ns/1ps
`include "gnss_macros.svh"

// Per-channel configuration from the register block.
interface chan_cfg_if import gnss_pkg::*; ();
   logic              enable;
   logic              restart;
   prn_t              prn;
   logic [`NCO_W-1:0] carr_inc;
   logic [`NCO_W-1:0] code_inc;

   modport regs (output enable, restart, prn, carr_inc, code_inc);
   modport chan (input enable, restart, prn, carr_inc, code_inc);
endinterface

// Dump results for all channels, plus read-clear back from the host side.
interface chan_res_if import gnss_pkg::*; ();
   chan_res_t               res [`N_CHANNELS];
   logic [`N_CHANNELS-1:0]  rd_clr;

   modport coll (output res, input rd_clr);
   modport regs (input res, output rd_clr);
endinterface

// File: rtl/sample_feed.sv
`timescale 1ns/1ps

module sample_feed import gnss_pkg::*; (
   input  logic    clk,
   input  logic    i_rst_n,
   input  logic    i_clk_sample,
   input  logic    i_sample_sign,
   input  logic    i_sample_mag,
   output logic    o_strobe,
   output sample_t o_sample
);

   // Two sync stages, then one more for the edge detect.
   logic [2:0] clk_sync;
   sample_t    d_sync1;
   sample_t    d_sync2;
   logic       edge_det;

   assign edge_det = clk_sync[1] & ~clk_sync[2];

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         clk_sync <= '0;
         o_strobe <= 1'b0;
      end else begin
         clk_sync <= {clk_sync[1:0], i_clk_sample};
         o_strobe <= edge_det;
      end
   end

   // Data follows the same two stages so it lines up with the edge.
   always_ff @(posedge clk) begin
      d_sync1 <= '{sign: i_sample_sign, mag: i_sample_mag};
      d_sync2 <= d_sync1;
      if (edge_det)
         o_sample <= d_sync2;
   end

endmodule

// File: rtl/ca_code_gen.sv
`timescale 1ns/1ps

module ca_code_gen import gnss_pkg::*; (
   input  logic clk,
   input  logic i_rst_n,
   input  logic i_restart,
   input  logic i_advance,
   input  prn_t i_prn,
   output logic o_chip
);

   // Stage numbers match the ICD, stage 1 takes the feedback.
   logic [10:1] g1;
   logic [10:1] g2;
   logic        g1_fb;
   logic        g2_fb;
   tap_pair_t   taps;

   // G1 = 1 + x^3 + x^10.
   assign g1_fb = g1[3] ^ g1[10];

   // G2 = 1 + x^2 + x^3 + x^6 + x^8 + x^9 + x^10.
   assign g2_fb = g2[2] ^ g2[3] ^ g2[6] ^ g2[8] ^ g2[9] ^ g2[10];

   assign taps = prn_taps(i_prn);

   // Logic 1 is chip value -1.
   assign o_chip = g1[10] ^ g2[taps[1]] ^ g2[taps[0]];

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         g1 <= '1;
         g2 <= '1;
      end else if (i_restart) begin
         g1 <= '1;
         g2 <= '1;
      end else if (i_advance) begin
         g1 <= {g1[9:1], g1_fb};
         g2 <= {g2[9:1], g2_fb};
      end
   end

endmodule

// File: rtl/corr_channel.sv
`timescale 1ns/1ps
`include "gnss_macros.svh"

module corr_channel import gnss_pkg::*; (
   input  logic                     clk,
   input  logic                     i_rst_n,
   input  logic                     i_strobe,
   input  sample_t                  i_sample,
   chan_cfg_if.chan                 cfg,
   output logic                     o_dump_valid,
   output logic signed [`ACC_W-1:0] o_i_sum,
   output logic signed [`ACC_W-1:0] o_q_sum
);

   localparam int CNT_W = $clog2(`DUMP_LEN);

   logic [`NCO_W-1:0] carr_phase;
   logic [`NCO_W-1:0] code_phase;
   logic [`NCO_W:0]   code_nxt;
   logic [CNT_W-1:0]  cnt;
   logic              step;
   logic              chip;
   logic signed [2:0] samp_v;
   carr_t             cos_v;
   carr_t             sin_v;
   logic signed [3:0] i_term;
   logic signed [3:0] q_term;

   assign step     = i_strobe & cfg.enable;
   assign code_nxt = {1'b0, code_phase} + {1'b0, cfg.code_inc};

   ca_code_gen u_code (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_restart (cfg.restart),
      .i_advance (step & code_nxt[`NCO_W]),
      .i_prn     (cfg.prn),
      .o_chip    (chip)
   );

   ////////////////////
   // Wipe-off
   ////////////////////

   always_comb begin
      samp_v = i_sample.mag ? 3'sd3 : 3'sd1;
      if (i_sample.sign)
         samp_v = -samp_v;
      case (carr_phase[`NCO_W-1 -: 2])
         2'd0:    begin cos_v = 2'sd1;  sin_v = 2'sd0;  end
         2'd1:    begin cos_v = 2'sd0;  sin_v = 2'sd1;  end
         2'd2:    begin cos_v = -2'sd1; sin_v = 2'sd0;  end
         default: begin cos_v = 2'sd0;  sin_v = -2'sd1; end
      endcase
      i_term = samp_v * cos_v;
      q_term = -(samp_v * sin_v);
      // Chip of -1 flips both arms.
      if (chip) begin
         i_term = -i_term;
         q_term = -q_term;
      end
   end

   ////////////////////
   // Accumulate and dump
   ////////////////////

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         carr_phase   <= '0;
         code_phase   <= '0;
         cnt          <= '0;
         o_dump_valid <= 1'b0;
         o_i_sum      <= '0;
         o_q_sum      <= '0;
      end else if (cfg.restart) begin
         carr_phase   <= '0;
         code_phase   <= '0;
         cnt          <= '0;
         o_dump_valid <= 1'b0;
         o_i_sum      <= '0;
         o_q_sum      <= '0;
      end else begin
         o_dump_valid <= 1'b0;
         // Sums stay valid for the dump cycle only.
         if (o_dump_valid) begin
            o_i_sum <= '0;
            o_q_sum <= '0;
         end
         if (step) begin
            carr_phase <= carr_phase + cfg.carr_inc;
            code_phase <= code_nxt[`NCO_W-1:0];
            o_i_sum    <= o_i_sum + `ACC_W'(i_term);
            o_q_sum    <= o_q_sum + `ACC_W'(q_term);
            cnt        <= cnt + 1'b1;
            if (cnt == CNT_W'(`DUMP_LEN - 1))
               o_dump_valid <= 1'b1;
         end
      end
   end

endmodule

// File: rtl/dump_collect.sv
`timescale 1ns/1ps
`include "gnss_macros.svh"

module dump_collect (
   input  logic                     clk,
   input  logic                     i_rst_n,
   input  logic [`N_CHANNELS-1:0]   i_dump_valid,
   input  logic signed [`ACC_W-1:0] i_i_sum [`N_CHANNELS],
   input  logic signed [`ACC_W-1:0] i_q_sum [`N_CHANNELS],
   chan_res_if.coll                 res
);

   localparam int PTR_W = $clog2(`N_CHANNELS);

   logic [`N_CHANNELS-1:0]   pend;
   logic signed [`ACC_W-1:0] pend_i [`N_CHANNELS];
   logic signed [`ACC_W-1:0] pend_q [`N_CHANNELS];
   logic [PTR_W-1:0]         rr_ptr;
   logic [PTR_W-1:0]         sel;
   logic signed [2*`ACC_W-1:0] sq_i;
   logic signed [2*`ACC_W-1:0] sq_q;
   logic [`PWR_W-1:0]        pwr;

   // Sums wait here until the power unit takes them.
   always_ff @(posedge clk) begin
      for (int c = 0; c < `N_CHANNELS; c++) begin
         if (i_dump_valid[c]) begin
            pend_i[c] <= i_i_sum[c];
            pend_q[c] <= i_q_sum[c];
         end
      end
   end

   ////////////////////
   // Round robin pick
   ////////////////////

   always_comb begin
      int unsigned idx;
      sel = rr_ptr;
      for (int k = `N_CHANNELS - 1; k >= 0; k--) begin
         idx = (int'(rr_ptr) + k) % `N_CHANNELS;
         if (pend[idx])
            sel = PTR_W'(idx);
      end
   end

   // Shared power unit.
   always_comb begin
      sq_i = pend_i[sel] * pend_i[sel];
      sq_q = pend_q[sel] * pend_q[sel];
      pwr  = `PWR_W'($unsigned(sq_i)) + `PWR_W'($unsigned(sq_q));
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pend   <= '0;
         rr_ptr <= '0;
         for (int c = 0; c < `N_CHANNELS; c++)
            res.res[c] <= '0;
      end else begin
         for (int c = 0; c < `N_CHANNELS; c++) begin
            if (res.rd_clr[c]) begin
               res.res[c].ready   <= 1'b0;
               res.res[c].overrun <= 1'b0;
            end
         end
         if (|pend) begin
            pend[sel]            <= 1'b0;
            rr_ptr               <= PTR_W'((int'(sel) + 1) % `N_CHANNELS);
            res.res[sel].i_sum   <= pend_i[sel];
            res.res[sel].q_sum   <= pend_q[sel];
            res.res[sel].power   <= pwr;
            res.res[sel].ready   <= 1'b1;
            // Unread result is lost.
            res.res[sel].overrun <= ~res.rd_clr[sel] &
                                    (res.res[sel].ready | res.res[sel].overrun);
         end
         // New dumps after the clear, so a same-cycle dump is kept.
         for (int c = 0; c < `N_CHANNELS; c++) begin
            if (i_dump_valid[c])
               pend[c] <= 1'b1;
         end
      end
   end

endmodule

// File: rtl/apb_regs.sv
`timescale 1ns/1ps
`include "gnss_macros.svh"

module apb_regs import gnss_pkg::*; (
   input  logic               clk,
   input  logic               i_rst_n,
   input  logic               i_psel,
   input  logic               i_penable,
   input  logic               i_pwrite,
   input  logic [`APB_AW-1:0] i_paddr,
   input  logic [`APB_DW-1:0] i_pwdata,
   output logic [`APB_DW-1:0] o_prdata,
   chan_cfg_if.regs           cfg [`N_CHANNELS],
   chan_res_if.regs           res
);

   localparam int CH_W = $clog2(`N_CHANNELS);

   logic                   wr_en;
   logic                   rd_setup;
   logic [1:0]             region;
   logic [CH_W-1:0]        ch_sel;
   logic [1:0]             reg_sel;
   logic [`APB_DW-1:0]     rd_mux;
   logic [`N_CHANNELS-1:0] en_q;
   logic [`N_CHANNELS-1:0] restart_q;
   prn_t                   prn_q  [`N_CHANNELS];
   logic [`NCO_W-1:0]      carr_q [`N_CHANNELS];
   logic [`NCO_W-1:0]      code_q [`N_CHANNELS];

   // No wait states.
   assign wr_en    = i_psel & i_penable & i_pwrite;
   assign rd_setup = i_psel & ~i_penable & ~i_pwrite;
   assign region   = i_paddr[7:6];
   assign ch_sel   = i_paddr[4 +: CH_W];
   assign reg_sel  = i_paddr[3:2];

   ////////////////////
   // Config registers
   ////////////////////

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         en_q      <= '0;
         restart_q <= '0;
         for (int c = 0; c < `N_CHANNELS; c++) begin
            prn_q[c]  <= '0;
            carr_q[c] <= '0;
            code_q[c] <= '0;
         end
      end else begin
         restart_q <= '0;
         if (wr_en && region == 2'd0) begin
            case (reg_sel)
               2'd0: begin
                  en_q[ch_sel]      <= i_pwdata[0];
                  prn_q[ch_sel]     <= i_pwdata[12:8];
                  restart_q[ch_sel] <= 1'b1;
               end
               2'd1: carr_q[ch_sel] <= i_pwdata[`NCO_W-1:0];
               2'd2: code_q[ch_sel] <= i_pwdata[`NCO_W-1:0];
               default: ;
            endcase
         end
      end
   end

   for (genvar c = 0; c < `N_CHANNELS; c++) begin : g_cfg
      assign cfg[c].enable   = en_q[c];
      assign cfg[c].restart  = restart_q[c];
      assign cfg[c].prn      = prn_q[c];
      assign cfg[c].carr_inc = carr_q[c];
      assign cfg[c].code_inc = code_q[c];
   end

   ////////////////////
   // Read path
   ////////////////////

   // Status clears on the same edge that captures it.
   always_comb begin
      res.rd_clr = '0;
      if (rd_setup && region == 2'd0 && reg_sel == 2'd3)
         res.rd_clr[ch_sel] = 1'b1;
   end

   always_comb begin
      rd_mux = '0;
      case (region)
         2'd0: begin
            case (reg_sel)
               2'd0: rd_mux = {19'd0, prn_q[ch_sel], 7'd0, en_q[ch_sel]};
               2'd1: rd_mux = carr_q[ch_sel];
               2'd2: rd_mux = code_q[ch_sel];
               default: rd_mux = {30'd0, res.res[ch_sel].overrun, res.res[ch_sel].ready};
            endcase
         end
         2'd1: begin
            case (reg_sel)
               2'd0: rd_mux = {{(`APB_DW-`ACC_W){res.res[ch_sel].i_sum[`ACC_W-1]}},
                               res.res[ch_sel].i_sum};
               2'd1: rd_mux = {{(`APB_DW-`ACC_W){res.res[ch_sel].q_sum[`ACC_W-1]}},
                               res.res[ch_sel].q_sum};
               2'd2: rd_mux = res.res[ch_sel].power;
               default: rd_mux = '0;
            endcase
         end
         default: rd_mux = '0;
      endcase
   end

   // Captured in setup, shown in the access phase.
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n)
         o_prdata <= '0;
      else if (rd_setup)
         o_prdata <= rd_mux;
   end

endmodule

// File: rtl/gnss_corr_top.sv
`timescale 1ns/1ps
`include "gnss_macros.svh"

module gnss_corr_top import gnss_pkg::*; (
   input  logic               clk,
   input  logic               i_rst_n,
   // Host bus.
   input  logic               i_psel,
   input  logic               i_penable,
   input  logic               i_pwrite,
   input  logic [`APB_AW-1:0] i_paddr,
   input  logic [`APB_DW-1:0] i_pwdata,
   output logic [`APB_DW-1:0] o_prdata,
   // Front end, on its own clock.
   input  logic               i_clk_sample,
   input  logic               i_sample_sign,
   input  logic               i_sample_mag
);

   logic                     strobe;
   sample_t                  sample;
   logic [`N_CHANNELS-1:0]   dump_valid;
   logic signed [`ACC_W-1:0] i_sum [`N_CHANNELS];
   logic signed [`ACC_W-1:0] q_sum [`N_CHANNELS];

   chan_cfg_if cfg_if [`N_CHANNELS] ();
   chan_res_if res_if ();

   sample_feed u_feed (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_clk_sample  (i_clk_sample),
      .i_sample_sign (i_sample_sign),
      .i_sample_mag  (i_sample_mag),
      .o_strobe      (strobe),
      .o_sample      (sample)
   );

   ////////////////////
   // Channels
   ////////////////////

   for (genvar c = 0; c < `N_CHANNELS; c++) begin : g_chan
      corr_channel u_chan (
         .clk          (clk),
         .i_rst_n      (i_rst_n),
         .i_strobe     (strobe),
         .i_sample     (sample),
         .cfg          (cfg_if[c]),
         .o_dump_valid (dump_valid[c]),
         .o_i_sum      (i_sum[c]),
         .o_q_sum      (q_sum[c])
      );
   end

   dump_collect u_coll (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .i_dump_valid (dump_valid),
      .i_i_sum      (i_sum),
      .i_q_sum      (q_sum),
      .res          (res_if)
   );

   apb_regs u_regs (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_psel    (i_psel),
      .i_penable (i_penable),
      .i_pwrite  (i_pwrite),
      .i_paddr   (i_paddr),
      .i_pwdata  (i_pwdata),
      .o_prdata  (o_prdata),
      .cfg       (cfg_if),
      .res       (res_if)
   );

endmodule

// File: bench/gnss_corr_checker.sv
`timescale 1ns/1ps
`include "gnss_macros.svh"

module gnss_corr_checker (
   input logic                   clk,
   input logic                   i_rst_n,
   input logic                   i_psel,
   input logic                   i_penable,
   input logic                   i_strobe,
   input logic [`N_CHANNELS-1:0] i_dump_valid
);

   ////////////////////
   // Host bus
   ////////////////////

   // Access phase comes only after a setup cycle.
   assert property (@(posedge clk) disable iff (!i_rst_n)
      i_penable |-> i_psel && $past(i_psel) && !$past(i_penable))
      else $error("penable rose without a setup phase");

   ////////////////////
   // Dump and strobe
   ////////////////////

   assert property (@(posedge clk) disable iff (!i_rst_n)
      (|i_dump_valid) |=> ~|(i_dump_valid & $past(i_dump_valid)))
      else $error("dump valid held for more than one cycle");

   assert property (@(posedge clk) disable iff (!i_rst_n)
      i_strobe |=> !i_strobe)
      else $error("sample strobe held for more than one cycle");

endmodule

bind gnss_corr_top gnss_corr_checker u_chk (
   .clk          (clk),
   .i_rst_n      (i_rst_n),
   .i_psel       (i_psel),
   .i_penable    (i_penable),
   .i_strobe     (strobe),
   .i_dump_valid (dump_valid)
);

// File: bench/gnss_corr_tb.sv
`timescale 1ns/1ps
`include "gnss_macros.svh"

module gnss_corr_tb;

   typedef struct packed {
      logic [3:0]  batch;
      logic [1:0]  chan;
      logic [4:0]  prn;
      logic [31:0] carr;
      logic [31:0] code;
      logic        exp_rdy;
   } row_t;

   localparam int N_ROWS = 8;
   // Two extra dump lengths cover the overrun run.
   localparam int LIMIT = (N_ROWS + 2) * (`DUMP_LEN + 4) * 8 + 200;

   localparam row_t TABLE [N_ROWS] = '{
      '{4'd0, 2'd0, 5'd1,  32'h0000_0000, 32'hFFFF_FFFF, 1'b1},
      '{4'd1, 2'd1, 5'd2,  32'h4000_0000, 32'h8000_0000, 1'b1},
      '{4'd2, 2'd0, 5'd3,  32'h4000_0000, 32'hFFFF_FFFF, 1'b1},
      '{4'd2, 2'd1, 5'd5,  32'hC000_0000, 32'h8000_0000, 1'b1},
      '{4'd2, 2'd2, 5'd7,  32'h0000_0000, 32'h4000_0000, 1'b1},
      '{4'd2, 2'd3, 5'd10, 32'h8000_0000, 32'hFFFF_FFFF, 1'b1},
      '{4'd3, 2'd2, 5'd4,  32'h4000_0000, 32'hFFFF_FFFF, 1'b0},
      '{4'd4, 2'd2, 5'd4,  32'h4000_0000, 32'hFFFF_FFFF, 1'b1}
   };

   logic        clk;
   logic        i_rst_n;
   logic        i_psel;
   logic        i_penable;
   logic        i_pwrite;
   logic [7:0]  i_paddr;
   logic [31:0] i_pwdata;
   logic [31:0] o_prdata;
   logic        i_clk_sample;
   logic        i_sample_sign;
   logic        i_sample_mag;

   logic [31:0] lfsr;
   logic [1:0]  samp [256];
   int          cycles;
   int          errs;
   int          n_pass;
   int          n_fail;

   gnss_corr_top UUT (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_psel        (i_psel),
      .i_penable     (i_penable),
      .i_pwrite      (i_pwrite),
      .i_paddr       (i_paddr),
      .i_pwdata      (i_pwdata),
      .o_prdata      (o_prdata),
      .i_clk_sample  (i_clk_sample),
      .i_sample_sign (i_sample_sign),
      .i_sample_mag  (i_sample_mag)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= LIMIT) begin
         $display("Timeout, run went past %0d cycles", LIMIT);
         $display("test failed");
         $finish;
      end
   end

   ////////////////////
   // Helpers
   ////////////////////

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // G2 phase selector pairs, PRN 1 to 10.
   task automatic g2_select(input int prn, output int t1, output int t2);
      int a [10];
      int b [10];
      a = '{2, 3, 4, 5, 1, 2, 1, 2, 3, 2};
      b = '{6, 7, 8, 9, 9, 10, 8, 9, 10, 3};
      t1 = a[prn - 1];
      t2 = b[prn - 1];
   endtask

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      if (got !== exp) begin
         $display("FAIL %s got %h expected %h", name, got, exp);
         errs++;
      end
   endtask

   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
      @(negedge clk);
      i_psel    = 1'b1;
      i_penable = 1'b0;
      i_pwrite  = 1'b1;
      i_paddr   = addr;
      i_pwdata  = data;
      @(negedge clk);
      i_penable = 1'b1;
      @(negedge clk);
      i_psel    = 1'b0;
      i_penable = 1'b0;
   endtask

   task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
      @(negedge clk);
      i_psel    = 1'b1;
      i_penable = 1'b0;
      i_pwrite  = 1'b0;
      i_paddr   = addr;
      @(negedge clk);
      i_penable = 1'b1;
      @(negedge clk);
      data      = o_prdata;
      i_psel    = 1'b0;
      i_penable = 1'b0;
   endtask

   // Two LFSR steps per sample, sign then magnitude.
   task automatic gen_samples(input int n);
      for (int k = 0; k < n; k++) begin
         lfsr       = lfsr_next(lfsr);
         samp[k][1] = lfsr[0];
         lfsr       = lfsr_next(lfsr);
         samp[k][0] = lfsr[0];
      end
   endtask

   task automatic run_samples(input int n);
      for (int k = 0; k < n; k++) begin
         @(negedge clk);
         i_clk_sample  = 1'b1;
         i_sample_sign = samp[k][1];
         i_sample_mag  = samp[k][0];
         repeat (4) @(negedge clk);
         i_clk_sample = 1'b0;
         repeat (3) @(negedge clk);
      end
      repeat (8) @(negedge clk);
   endtask

   // Sums of the last full integration over n samples.
   task automatic chan_model(input int prn, input logic [31:0] carr_inc,
                             input logic [31:0] code_inc, input int n,
                             output int ei, output int eq);
      logic [10:1] g1;
      logic [10:1] g2;
      logic [31:0] carr;
      logic [32:0] code;
      int          t1;
      int          t2;
      int          val;
      int          cs;
      int          sn;
      int          sgn;
      logic        f1;
      logic        f2;
      g2_select(prn, t1, t2);
      g1   = '1;
      g2   = '1;
      carr = '0;
      code = '0;
      ei   = 0;
      eq   = 0;
      for (int s = 0; s < n; s++) begin
         if (s % `DUMP_LEN == 0) begin
            ei = 0;
            eq = 0;
         end
         val = samp[s][0] ? 3 : 1;
         if (samp[s][1])
            val = -val;
         case (carr[31:30])
            2'd0: begin cs = 1; sn = 0; end
            2'd1: begin cs = 0; sn = 1; end
            2'd2: begin cs = -1; sn = 0; end
            default: begin cs = 0; sn = -1; end
         endcase
         sgn = (g1[10] ^ g2[t1] ^ g2[t2]) ? -1 : 1;
         ei += val * cs * sgn;
         eq += -val * sn * sgn;
         carr = carr + carr_inc;
         code = {1'b0, code[31:0]} + {1'b0, code_inc};
         if (code[32]) begin
            f1 = g1[3] ^ g1[10];
            f2 = g2[2] ^ g2[3] ^ g2[6] ^ g2[8] ^ g2[9] ^ g2[10];
            g1 = {g1[9:1], f1};
            g2 = {g2[9:1], f2};
         end
      end
   endtask

   task automatic wait_ready(input int ch, output bit ok);
      logic [31:0] d;
      ok = 0;
      for (int t = 0; t < 40 && !ok; t++) begin
         apb_read(8'(ch * 16 + 12), d);
         if (d[0])
            ok = 1;
      end
   endtask

   task automatic check_results(input int ch, input int ei, input int eq);
      logic [31:0] d;
      apb_read(8'(8'h40 + ch * 16), d);
      check_val($sformatf("o_prdata ch%0d i_sum", ch), d, 32'(ei));
      apb_read(8'(8'h44 + ch * 16), d);
      check_val($sformatf("o_prdata ch%0d q_sum", ch), d, 32'(eq));
      apb_read(8'(8'h48 + ch * 16), d);
      check_val($sformatf("o_prdata ch%0d power", ch), d, 32'(ei * ei + eq * eq));
   endtask

   // Disables all channels and clears their status.
   task automatic quiesce();
      logic [31:0] d;
      for (int c = 0; c < `N_CHANNELS; c++)
         apb_write(8'(c * 16), 32'd0);
      for (int c = 0; c < `N_CHANNELS; c++)
         apb_read(8'(c * 16 + 12), d);
   endtask

   task automatic report(input string name, input int errs_before);
      if (errs == errs_before) begin
         $display("%s ... ok", name);
         n_pass++;
      end else begin
         $display("%s ... bad", name);
         n_fail++;
      end
   endtask

   ////////////////////
   // Main sequence
   ////////////////////

   initial begin
      logic [31:0] d;
      int          e0;
      int          ei;
      int          eq;
      int          n;
      bit          ok;
      i_rst_n       = 1'b0;
      i_psel        = 1'b0;
      i_penable     = 1'b0;
      i_pwrite      = 1'b0;
      i_paddr       = '0;
      i_pwdata      = '0;
      i_clk_sample  = 1'b0;
      i_sample_sign = 1'b0;
      i_sample_mag  = 1'b0;
      lfsr          = 32'h53b0e206;
      cycles        = 0;
      errs          = 0;
      n_pass        = 0;
      n_fail        = 0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      i_rst_n = 1'b1;

      e0 = errs;
      for (int c = 0; c < `N_CHANNELS; c++) begin
         apb_read(8'(c * 16 + 12), d);
         check_val($sformatf("o_prdata ch%0d status", c), d, 32'd0);
      end
      report("reset status", e0);

      for (int b = 0; b < 5; b++) begin
         quiesce();
         n = `DUMP_LEN;
         for (int r = 0; r < N_ROWS; r++) begin
            if (TABLE[r].batch == 4'(b)) begin
               apb_write(8'(TABLE[r].chan * 16 + 4), TABLE[r].carr);
               apb_write(8'(TABLE[r].chan * 16 + 8), TABLE[r].code);
               apb_write(8'(TABLE[r].chan * 16),
                         {19'd0, TABLE[r].prn, 7'd0, TABLE[r].exp_rdy});
               if (!TABLE[r].exp_rdy)
                  n = `DUMP_LEN + 16;
            end
         end
         gen_samples(n);
         run_samples(n);
         for (int r = 0; r < N_ROWS; r++) begin
            if (TABLE[r].batch == 4'(b)) begin
               e0 = errs;
               if (TABLE[r].exp_rdy) begin
                  chan_model(int'(TABLE[r].prn), TABLE[r].carr, TABLE[r].code, n, ei, eq);
                  wait_ready(int'(TABLE[r].chan), ok);
                  if (!ok) begin
                     $display("Channel %0d never reported ready", TABLE[r].chan);
                     errs++;
                  end
                  check_results(int'(TABLE[r].chan), ei, eq);
               end else begin
                  apb_read(8'(TABLE[r].chan * 16 + 12), d);
                  check_val($sformatf("o_prdata ch%0d status", TABLE[r].chan), d, 32'd0);
               end
               report($sformatf("row %0d ch%0d prn%0d", r, TABLE[r].chan, TABLE[r].prn),
                      e0);
            end
         end
      end

      // Two dumps without a status read in between.
      e0 = errs;
      quiesce();
      apb_write(8'h34, 32'h4000_0000);
      apb_write(8'h38, 32'hFFFF_FFFF);
      apb_write(8'h30, {19'd0, 5'd6, 7'd0, 1'b1});
      gen_samples(2 * `DUMP_LEN);
      run_samples(2 * `DUMP_LEN);
      chan_model(6, 32'h4000_0000, 32'hFFFF_FFFF, 2 * `DUMP_LEN, ei, eq);
      apb_read(8'h3C, d);
      check_val("o_prdata ch3 status", d, 32'd3);
      check_results(3, ei, eq);
      apb_read(8'h3C, d);
      check_val("o_prdata ch3 status after clear", d, 32'd0);
      report("overrun ch3 prn6", e0);

      $display("Tests: %0d ok, %0d bad, %0d errors", n_pass, n_fail, errs);
      if (errs == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

// File: files.f
+incdir+rtl
rtl/gnss_pkg.sv
rtl/gnss_ifs.sv
rtl/sample_feed.sv
rtl/ca_code_gen.sv
rtl/corr_channel.sv
rtl/dump_collect.sv
rtl/apb_regs.sv
rtl/gnss_corr_top.sv
bench/gnss_corr_checker.sv
bench/gnss_corr_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = gnss_corr_tb
FILELIST = files.f
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check the log"
	@echo "  clean  remove build output and log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
